// ==== ecc_pkg.sv ====
`default_nettype none

package ecc_pkg;

    localparam int DATA_W   = 118;
    localparam int PARITY_W = 8;
    localparam int HAM_W    = 7; // Also the index of the overall parity bit.

    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [PARITY_W-1:0] parity_t;
    typedef logic [HAM_W-1:0]    pos_t;

    // Outcome of a syndrome check.
    typedef enum logic [1:0] {
        ECC_OK     = 2'd0,
        ECC_SINGLE = 2'd1,
        ECC_DOUBLE = 2'd2
    } ecc_status_e;

    // Word entering the block, as read from memory or about to be written.
    typedef struct packed {
        data_t   data;
        parity_t parity;
        logic    bypass;
    } ecc_word_t;

    // Stage 1 register.
    typedef struct packed {
        logic    valid;
        data_t   data;
        parity_t syndrome;
        parity_t parity_gen; // Check bits recomputed from the data.
        logic    bypass;
    } ecc_check_t;

    // Block result after correction.
    typedef struct packed {
        data_t       data;
        parity_t     parity;
        ecc_status_e status;
    } ecc_result_t;

    // Codeword position (1-based) of data bit idx.
    // Data bits fill the positions that are not a power of two, so the first
    // candidate is idx + 3 and every power of two at or below the running
    // position pushes the bit one slot further up.
    function automatic pos_t data_position(input int unsigned idx);
        int unsigned pos;
        pos = idx + 3;
        for (int k = 2; k < HAM_W; k++) begin
            if (pos >= (32'd1 << k)) begin
                pos = pos + 1;
            end
        end
        return pos_t'(pos);
    endfunction

endpackage

`default_nettype wire

// ==== ecc_encoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_encoder
    import ecc_pkg::*;
(
    input  data_t   data,
    output parity_t parity
);

    // Select mask of the data bits that feed check bit k.
    // Hamming bits take the positions with bit k set; the top bit takes the
    // positions of even weight, which makes it the overall codeword parity.
    function automatic data_t check_mask(input int unsigned k);
        data_t mask;
        pos_t  pos;
        mask = '0;
        for (int i = 0; i < DATA_W; i++) begin
            pos = data_position(i);
            if (k < HAM_W) begin
                mask[i] = pos[k];
            end else begin
                mask[i] = ~^pos;
            end
        end
        return mask;
    endfunction

    genvar k;
    generate
        for (k = 0; k < PARITY_W; k++) begin : gen_check
            localparam data_t MASK = check_mask(k);

            assign parity[k] = ^(data & MASK); // Reduction XOR over the selected bits.
        end
    endgenerate

endmodule

`default_nettype wire

// ==== ecc_check_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_check_stage
    import ecc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  ecc_word_t  in_word,
    output ecc_check_t check_q
);

    parity_t parity_gen;
    parity_t syndrome;

    logic    valid_q;
    data_t   data_q;
    parity_t syndrome_q;
    parity_t parity_gen_q;
    logic    bypass_q;

    ecc_encoder u_encoder (
        .data   (in_word.data),
        .parity (parity_gen)
    );

    // A clean word gives a zero syndrome.
    assign syndrome = in_word.parity ^ parity_gen;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    // Payload only moves with a qualified word.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            data_q       <= in_word.data;
            syndrome_q   <= syndrome;
            parity_gen_q <= parity_gen;
            bypass_q     <= in_word.bypass;
        end
    end

    assign check_q = '{
        valid:      valid_q,
        data:       data_q,
        syndrome:   syndrome_q,
        parity_gen: parity_gen_q,
        bypass:     bypass_q
    };

endmodule

`default_nettype wire

// ==== ecc_correct_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_correct_stage
    import ecc_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  ecc_check_t  check_q,
    output logic        out_valid,
    output ecc_result_t result
);

    // Syndrome that a flip of data bit idx produces.
    function automatic parity_t expected_syndrome(input int unsigned idx);
        pos_t pos;
        pos = data_position(idx);
        return {~^pos, pos};
    endfunction

    data_t       hit;          // One-hot on a data-position match.
    logic        check_single; // A single check bit failed.
    ecc_status_e status;
    data_t       data_fix;

    ecc_status_e status_q;
    data_t       data_q;
    parity_t     parity_q;

    genvar i;
    generate
        for (i = 0; i < DATA_W; i++) begin : gen_match
            localparam parity_t EXP_SYN = expected_syndrome(i);

            assign hit[i] = (check_q.syndrome == EXP_SYN);
        end
    endgenerate

    assign check_single = $onehot(check_q.syndrome);

    always_comb begin
        if (check_q.bypass || check_q.syndrome == '0) begin
            status = ECC_OK;
        end else if (check_single || |hit) begin
            status = ECC_SINGLE;
        end else begin
            status = ECC_DOUBLE; // Data passes through uncorrected.
        end
    end

    // Hit is all zeros for check-bit errors and double errors.
    assign data_fix = check_q.bypass ? check_q.data : (check_q.data ^ hit);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            status_q  <= ECC_OK;
        end else begin
            out_valid <= check_q.valid;
            status_q  <= check_q.valid ? status : ECC_OK; // Idle cycles report no error.
        end
    end

    always_ff @(posedge clk) begin
        if (check_q.valid) begin
            data_q   <= data_fix;
            parity_q <= check_q.parity_gen;
        end
    end

    assign result = '{
        data:   data_q,
        parity: parity_q,
        status: status_q
    };

endmodule

`default_nettype wire

// ==== ecc_118_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_118_top
    import ecc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  ecc_word_t in_word,
    output logic      out_valid,
    output data_t     data_out,
    output parity_t   parity_out,
    output logic      sbit_err,
    output logic      dbit_err
);

    ecc_check_t  check_q;
    ecc_result_t result;

    // Stage 1 encodes and forms the syndrome.
    ecc_check_stage u_check_stage (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_word  (in_word),
        .check_q  (check_q)
    );

    // Stage 2 classifies and corrects.
    ecc_correct_stage u_correct_stage (
        .clk       (clk),
        .rst       (rst),
        .check_q   (check_q),
        .out_valid (out_valid),
        .result    (result)
    );

    assign data_out   = result.data;
    assign parity_out = result.parity; // Write-path check bits of the input data.

    // Flags only mean something on a valid output cycle.
    assign sbit_err = out_valid && (result.status == ECC_SINGLE);
    assign dbit_err = out_valid && (result.status == ECC_DOUBLE);

endmodule

`default_nettype wire

// ==== ecc_118_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_118_chk
    import ecc_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input ecc_check_t  check_q,
    input logic        out_valid,
    input ecc_result_t result
);

    // Error statuses only ride along with a valid output.
    a_status_idle: assert property (
        @(posedge clk) disable iff (rst)
        !out_valid |-> (result.status != ECC_SINGLE && result.status != ECC_DOUBLE)
    ) else $error("Error status present while out_valid is low.");

    a_reset_clears_valid: assert property (
        @(posedge clk) rst |=> !out_valid
    ) else $error("out_valid high in the cycle after reset.");

    a_bypass_data: assert property (
        @(posedge clk) disable iff (rst)
        (check_q.valid && check_q.bypass) |=> (result.data == $past(check_q.data))
    ) else $error("Bypass word was altered by the correct stage.");

endmodule

bind ecc_correct_stage ecc_118_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .check_q   (check_q),
    .out_valid (out_valid),
    .result    (result)
);

`default_nettype wire

// ==== ecc_118_scoreboard.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_118_scoreboard
    import ecc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  ecc_word_t in_word,
    input  logic      exp_sbit,
    input  logic      exp_dbit,
    input  logic      out_valid,
    input  data_t     data_out,
    input  parity_t   parity_out,
    input  logic      sbit_err,
    input  logic      dbit_err,
    output int        value_errors,
    output int        other_errors,
    output int        pending
);

    typedef struct packed {
        data_t   data;
        parity_t parity;
        logic    sbit;
        logic    dbit;
        int      due;
    } expect_t;

    int      pos_tab [DATA_W];
    int      cycle;
    expect_t exp_q[$];

    // Walk the codeword positions and skip the powers of two.
    initial begin
        int p;
        p = 0;
        for (int i = 0; i < DATA_W; i++) begin
            p = p + 1;
            while ((p & (p - 1)) == 0) begin
                p = p + 1;
            end
            pos_tab[i] = p;
        end
    end

    function automatic parity_t check_bits(input data_t d);
        parity_t c;
        c = '0;
        for (int i = 0; i < DATA_W; i++) begin
            for (int k = 0; k < 7; k++) begin
                if (pos_tab[i][k]) begin
                    c[k] = c[k] ^ d[i];
                end
            end
            if ($countones(pos_tab[i]) % 2 == 0) begin
                c[7] = c[7] ^ d[i];
            end
        end
        return c;
    endfunction

    // Flips the data bit whose syndrome matches; other syndromes leave the data alone.
    function automatic data_t corrected_data(input ecc_word_t w);
        data_t   d;
        parity_t syn;
        parity_t exp_syn;
        d = w.data;
        syn = w.parity ^ check_bits(w.data);
        if (!w.bypass) begin
            for (int i = 0; i < DATA_W; i++) begin
                exp_syn[6:0] = pos_tab[i][6:0];
                exp_syn[7]   = ($countones(pos_tab[i]) % 2) == 0;
                if (syn == exp_syn) begin
                    d[i] = ~d[i];
                end
            end
        end
        return d;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] want);
        if (got !== want) begin
            value_errors = value_errors + 1;
            $display("[ERROR] %s: got %h, expected %h", name, got, want);
        end
    endtask

    // Outputs are stable at the falling edge.
    always @(negedge clk) begin
        expect_t e;
        if (rst !== 1'b0) begin
            value_errors = 0;
            other_errors = 0;
            cycle        = 0;
            exp_q.delete();
        end else begin
            cycle = cycle + 1;
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    other_errors = other_errors + 1;
                    $display("Output word at cycle %0d has no input that matches it.", cycle);
                end else begin
                    e = exp_q.pop_front();
                    if (e.due != cycle) begin
                        other_errors = other_errors + 1;
                        $display("Output word came at cycle %0d but was due at cycle %0d.",
                                 cycle, e.due);
                    end
                    report_mismatch("data_out", 128'(data_out), 128'(e.data));
                    report_mismatch("parity_out", 128'(parity_out), 128'(e.parity));
                    report_mismatch("sbit_err", 128'(sbit_err), 128'(e.sbit));
                    report_mismatch("dbit_err", 128'(dbit_err), 128'(e.dbit));
                end
            end else begin
                report_mismatch("sbit_err", 128'(sbit_err), 128'(0));
                report_mismatch("dbit_err", 128'(dbit_err), 128'(0));
                if (exp_q.size() != 0 && exp_q[0].due < cycle) begin
                    other_errors = other_errors + 1;
                    $display("Word due at cycle %0d never came out.", exp_q[0].due);
                    e = exp_q.pop_front();
                end
            end
            if (in_valid) begin
                e.data   = corrected_data(in_word);
                e.parity = check_bits(in_word.data);
                e.sbit   = exp_sbit;
                e.dbit   = exp_dbit;
                e.due    = cycle + 2;
                exp_q.push_back(e);
            end
        end
        pending = exp_q.size();
    end

endmodule

`default_nettype wire

// ==== ecc_118_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_118_tb
    import ecc_pkg::*;
();

    localparam int NONE    = -1;   // No flip.
    localparam int CHK     = 1000; // CHK + k flips check bit k.
    localparam int RND     = 2000; // Flip a data bit picked by $random.
    localparam int RST_CYC = 16;
    localparam int SLACK   = 20;

    typedef enum logic [1:0] {
        SRC_ZERO,
        SRC_ONES,
        SRC_RAND
    } src_e;

    // One row of the stimulus table with its expected flags.
    typedef struct packed {
        src_e src;
        int   a;
        int   b;
        logic bypass;
        logic exp_sbit;
        logic exp_dbit;
        int   gap; // Idle cycles after the word.
    } stim_t;

    logic      clk;
    logic      rst;
    logic      in_valid;
    ecc_word_t in_word;
    logic      out_valid;
    data_t     data_out;
    parity_t   parity_out;
    logic      sbit_err;
    logic      dbit_err;
    logic      exp_sbit;
    logic      exp_dbit;

    int        value_errors;
    int        other_errors;
    int        pending;
    int        cycle_count = 0;
    int        cycle_limit = 0;
    integer    seed;
    stim_t     table_q[$];

    ecc_118_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_word    (in_word),
        .out_valid  (out_valid),
        .data_out   (data_out),
        .parity_out (parity_out),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    ecc_118_scoreboard u_scoreboard (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_word      (in_word),
        .exp_sbit     (exp_sbit),
        .exp_dbit     (exp_dbit),
        .out_valid    (out_valid),
        .data_out     (data_out),
        .parity_out   (parity_out),
        .sbit_err     (sbit_err),
        .dbit_err     (dbit_err),
        .value_errors (value_errors),
        .other_errors (other_errors),
        .pending      (pending)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles: the DUT did not deliver every word.",
                     cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    // Data bit i sits at the (i+1)-th codeword position that is not a power of two.
    function automatic int codeword_position(input int idx);
        int p;
        int n;
        p = 0;
        n = -1;
        while (n < idx) begin
            p = p + 1;
            if ((p & (p - 1)) != 0) begin
                n = n + 1;
            end
        end
        return p;
    endfunction

    function automatic parity_t clean_check_bits(input data_t d);
        parity_t c;
        int      p;
        logic    even;
        c = '0;
        for (int i = 0; i < DATA_W; i++) begin
            p = codeword_position(i);
            even = ~^p[6:0];
            for (int k = 0; k < 7; k++) begin
                c[k] = c[k] ^ (d[i] & p[k]);
            end
            c[7] = c[7] ^ (d[i] & even); // Overall parity over even-weight positions.
        end
        return c;
    endfunction

    task automatic flip_bit(input int idx, inout data_t d, inout parity_t p);
        int bit_idx;
        bit_idx = idx;
        if (bit_idx == RND) begin
            bit_idx = $unsigned($random(seed)) % DATA_W;
        end
        if (bit_idx >= CHK) begin
            p[bit_idx - CHK] = ~p[bit_idx - CHK];
        end else if (bit_idx >= 0) begin
            d[bit_idx] = ~d[bit_idx];
        end
    endtask

    task automatic add_entry(input src_e src, input int a, input int b, input int byp,
                             input int sbit, input int dbit, input int gap);
        table_q.push_back('{src: src, a: a, b: b, bypass: (byp != 0),
                            exp_sbit: (sbit != 0), exp_dbit: (dbit != 0), gap: gap});
    endtask

    task automatic build_table();
        add_entry(SRC_ZERO, NONE, NONE, 0, 0, 0, 0);
        add_entry(SRC_ONES, NONE, NONE, 0, 0, 0, 0);
        add_entry(SRC_RAND, NONE, NONE, 0, 0, 0, 2);
        add_entry(SRC_RAND, NONE, NONE, 0, 0, 0, 0);
        add_entry(SRC_RAND, 0, NONE, 0, 1, 0, 0);
        add_entry(SRC_RAND, 1, NONE, 0, 1, 0, 0);
        add_entry(SRC_RAND, 3, NONE, 0, 1, 0, 0);
        add_entry(SRC_RAND, 57, NONE, 0, 1, 0, 0);
        add_entry(SRC_RAND, 116, NONE, 0, 1, 0, 0);
        add_entry(SRC_RAND, 117, NONE, 0, 1, 0, 1);
        add_entry(SRC_ZERO, 0, NONE, 0, 1, 0, 0);
        add_entry(SRC_ONES, 117, NONE, 0, 1, 0, 0);
        add_entry(SRC_RAND, RND, NONE, 0, 1, 0, 0);
        add_entry(SRC_RAND, RND, NONE, 0, 1, 0, 3);
        add_entry(SRC_RAND, RND, NONE, 0, 1, 0, 0);
        for (int k = 0; k < 8; k++) begin
            add_entry(SRC_RAND, CHK + k, NONE, 0, 1, 0, 0);
        end
        add_entry(SRC_RAND, 0, 117, 0, 0, 1, 0);
        add_entry(SRC_RAND, 3, 57, 0, 0, 1, 0);
        add_entry(SRC_RAND, 116, 117, 0, 0, 1, 0);
        add_entry(SRC_RAND, 5, CHK + 0, 0, 0, 1, 0);
        add_entry(SRC_RAND, 117, CHK + 7, 0, 0, 1, 0);
        add_entry(SRC_RAND, CHK + 7, 60, 0, 0, 1, 0);
        add_entry(SRC_RAND, CHK + 0, CHK + 7, 0, 0, 1, 0);
        add_entry(SRC_RAND, CHK + 3, CHK + 4, 0, 0, 1, 0);
        add_entry(SRC_ZERO, 1, 2, 0, 0, 1, 5);
        add_entry(SRC_RAND, NONE, NONE, 1, 0, 0, 0);
        add_entry(SRC_RAND, 57, NONE, 1, 0, 0, 0);
        add_entry(SRC_RAND, CHK + 2, NONE, 1, 0, 0, 0);
        add_entry(SRC_RAND, 0, 1, 1, 0, 0, 0);
        add_entry(SRC_RAND, NONE, NONE, 0, 0, 0, 0);
        add_entry(SRC_RAND, 57, NONE, 0, 1, 0, 0);
    endtask

    task automatic apply_entry(input stim_t s);
        data_t        d;
        parity_t      p;
        logic [127:0] r;
        case (s.src)
            SRC_ZERO: d = '0;
            SRC_ONES: d = '1;
            default: begin
                r = {$random(seed), $random(seed), $random(seed), $random(seed)};
                d = r[DATA_W-1:0];
            end
        endcase
        p = clean_check_bits(d);
        flip_bit(s.a, d, p);
        flip_bit(s.b, d, p);
        in_word  = '{data: d, parity: p, bypass: s.bypass};
        exp_sbit = s.exp_sbit;
        exp_dbit = s.exp_dbit;
        in_valid = 1'b1;
    endtask

    initial begin
        int total;
        seed     = 58;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_word  = '0;
        exp_sbit = 1'b0;
        exp_dbit = 1'b0;
        build_table();
        total = RST_CYC + SLACK;
        foreach (table_q[n]) begin
            total = total + 1 + table_q[n].gap;
        end
        cycle_limit = total;

        repeat (RST_CYC) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (table_q[n]) begin
            apply_entry(table_q[n]);
            @(posedge clk);
            #1; // Inputs change just after the edge.
            in_valid = 1'b0;
            repeat (table_q[n].gap) begin
                @(posedge clk);
                #1;
            end
        end

        while (pending != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk); // The scoreboard watches the idle flags here.

        $display("Error counts: %0d value errors, %0d other errors.",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
ecc_pkg.sv
ecc_encoder.sv
ecc_check_stage.sv
ecc_correct_stage.sv
ecc_118_top.sv
ecc_118_chk.sv
ecc_118_scoreboard.sv
ecc_118_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module ecc_118_tb -f project.f &&
./obj_dir/Vecc_118_tb | tee /dev/stderr | grep "Testbench passed" > /dev/null &&
echo "Simulation run passed" ||
{ echo "Simulation run failed"; exit 1; }
